// File: rtl/amoPkg.sv
package amoPkg;

	// ==============================
	// Data path
	// ==============================

	// Memory word and operand width
	// The lane split in the ALU assumes 64 bits
	localparam int dataWidth = 64;

	// Result given by the ALU for an op code it does not know
	// This value never reaches memory
	localparam logic [dataWidth-1:0] poisonValue = 64'hDEADDEADDEADDEAD;

	// ==============================
	// Operation encoding
	// ==============================

	// Codes 11 to 15 are unused and flagged as invalid
	typedef enum logic [3:0]
	{
		opSwap = 4'd0,
		opAdd  = 4'd1,
		opAnd  = 4'd2,
		opOr   = 4'd3,
		opXor  = 4'd4,
		// Shift counts are masked to the lane width
		opShl  = 4'd5,
		opShr  = 4'd6,
		// Signed compares
		opMin  = 4'd7,
		opMax  = 4'd8,
		// Unsigned compares
		opMinu = 4'd9,
		opMaxu = 4'd10
	} amoOp;

	// ==============================
	// Lane size encoding
	// ==============================

	// Every operation is applied to each lane on its own
	// A double lane covers the whole word
	typedef enum logic [1:0]
	{
		laneByte   = 2'd0,
		laneHalf   = 2'd1,
		laneWord   = 2'd2,
		laneDouble = 2'd3
	} laneSize;

endpackage

// File: rtl/amoAlu.sv
module amoAlu import amoPkg::*;
(
	input  amoOp                 op,
	input  laneSize              size,
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] result,
	output logic                 invalid
);

	// Lane geometry for the selected size
	logic [6:0] laneBits;
	logic [3:0] laneCount;
	logic [dataWidth-1:0] laneMask;

	// One lane of the operation
	// Both inputs arrive zero-extended; the caller masks the result
	function automatic logic [dataWidth-1:0] laneOp
	(
		input amoOp                 fop,
		input logic [dataWidth-1:0] x,
		input logic [dataWidth-1:0] y,
		input logic [6:0]           bits
	);
		logic [6:0] pad;
		logic [5:0] count;
		logic signed [dataWidth-1:0] xs;
		logic signed [dataWidth-1:0] ys;
		pad = 7'(dataWidth) - bits;
		// Only the low bits that fit the lane take part in a shift
		count = y[5:0] & (bits[5:0] - 6'd1);
		// Sign-extend the lane for the signed compares
		xs = $signed(x << pad) >>> pad;
		ys = $signed(y << pad) >>> pad;
		case (fop)
			opSwap: laneOp = y;
			opAdd:  laneOp = x + y;
			opAnd:  laneOp = x & y;
			opOr:   laneOp = x | y;
			opXor:  laneOp = x ^ y;
			opShl:  laneOp = x << count;
			opShr:  laneOp = x >> count;
			opMin:  laneOp = (xs < ys) ? x : y;
			opMax:  laneOp = (xs > ys) ? x : y;
			opMinu: laneOp = (x < y) ? x : y;
			opMaxu: laneOp = (x > y) ? x : y;
			default: laneOp = '0;
		endcase
	endfunction

	// ==============================
	// Op code check
	// ==============================

	always_comb
	begin
		case (op)
			opSwap, opAdd, opAnd, opOr, opXor, opShl, opShr,
			opMin, opMax, opMinu, opMaxu:
				invalid = 1'b0;
			default:
				invalid = 1'b1;
		endcase
	end

	// ==============================
	// Lane split
	// ==============================

	always_comb
	begin
		case (size)
			laneByte:
			begin
				laneBits = 7'd8;
				laneCount = 4'd8;
			end
			laneHalf:
			begin
				laneBits = 7'd16;
				laneCount = 4'd4;
			end
			laneWord:
			begin
				laneBits = 7'd32;
				laneCount = 4'd2;
			end
			default:
			begin
				laneBits = 7'd64;
				laneCount = 4'd1;
			end
		endcase
	end

	assign laneMask = {dataWidth{1'b1}} >> (7'(dataWidth) - laneBits);

	// Each lane is computed in isolation, so carries stop at the lane edge
	always_comb
	begin
		logic [dataWidth-1:0] laneA;
		logic [dataWidth-1:0] laneB;
		logic [dataWidth-1:0] laneR;
		int unsigned base;
		result = '0;
		laneA = '0;
		laneB = '0;
		laneR = '0;
		base = 0;
		for (int i = 0; i < 8; i++)
		begin
			if (i < laneCount)
			begin
				base = i * laneBits;
				laneA = (a >> base) & laneMask;
				laneB = (b >> base) & laneMask;
				laneR = laneOp(op, laneA, laneB, laneBits) & laneMask;
				result = result | (laneR << base);
			end
		end
		if (invalid)
			result = poisonValue;
	end

endmodule

// File: rtl/amoMemory.sv
module amoMemory import amoPkg::*;
#(
	parameter int addrWidth = 4
)
(
	input  logic                 clk,
	input  logic [addrWidth-1:0] addr,
	input  logic                 writeEnable,
	input  logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData
);

	localparam int depth = 1 << addrWidth;

	logic [dataWidth-1:0] mem [0:depth-1];

	// Registered read on every edge
	// A write to the address being read shows up one access later
	always_ff @(posedge clk)
	begin
		if (writeEnable)
			mem[addr] <= writeData;
		readData <= mem[addr];
	end

endmodule

// File: rtl/amoSequencer.sv
module amoSequencer import amoPkg::*;
#(
	parameter int addrWidth = 4
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	input  amoOp                 op,
	input  laneSize              size,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] operand,
	output logic                 ack,
	output logic [dataWidth-1:0] oldValue,
	output logic                 error,
	output logic [addrWidth-1:0] memAddr,
	output logic                 writeEnable,
	output logic [dataWidth-1:0] writeData,
	input  logic [dataWidth-1:0] readData,
	output amoOp                 aluOp,
	output laneSize              aluSize,
	output logic [dataWidth-1:0] aluB,
	input  logic [dataWidth-1:0] aluResult,
	input  logic                 aluInvalid
);

	typedef enum logic [1:0]
	{
		stateIdle,
		stateRead,
		stateModify,
		stateDone
	} seqState;

	seqState state;

	// Request fields sampled once when the request is accepted
	amoOp                 reqOp;
	laneSize              reqSize;
	logic [addrWidth-1:0] reqAddr;
	logic [dataWidth-1:0] reqOperand;

	// ==============================
	// Control FSM
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			ack <= 1'b0;
			error <= 1'b0;
		end
		else
		begin
			case (state)
				stateIdle:
					if (req)
						state <= stateRead;
				// Memory registers the old word on this edge
				stateRead:
					state <= stateModify;
				stateModify:
				begin
					ack <= 1'b1;
					error <= aluInvalid;
					state <= stateDone;
				end
				// Hold the response until the requester lets go
				default:
					if (!req)
					begin
						ack <= 1'b0;
						state <= stateIdle;
					end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == stateIdle && req)
		begin
			reqOp <= op;
			reqSize <= size;
			reqAddr <= addr;
			reqOperand <= operand;
		end
		if (state == stateModify)
			oldValue <= readData;
	end

	// ==============================
	// Memory and ALU side
	// ==============================

	assign memAddr = reqAddr;
	assign aluOp = reqOp;
	assign aluSize = reqSize;
	assign aluB = reqOperand;
	assign writeData = aluResult;

	// One write per request and none for an unknown op
	assign writeEnable = (state == stateModify) && !aluInvalid;

	// ==============================
	// Assertions
	// ==============================

	// The write lands while no response is held, one edge before ack rises
	writeBeforeAck: assert property (@(posedge clk) disable iff (reset)
		writeEnable |-> !ack ##1 (ack && !error));

	// A skipped write must be reported as an error
	skipFlagsError: assert property (@(posedge clk) disable iff (reset)
		(state == stateModify && !writeEnable) |=> (ack && error));

	// Under the four-phase rule ack drops only after req has dropped
	ackHeld: assert property (@(posedge clk) disable iff (reset)
		(ack && req) |=> ack);

endmodule

// File: rtl/amoUnit.sv
module amoUnit import amoPkg::*;
#(
	parameter int addrWidth = 4
)
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req,
	input  amoOp                 op,
	input  laneSize              size,
	input  logic [addrWidth-1:0] addr,
	input  logic [dataWidth-1:0] operand,
	output logic                 ack,
	output logic [dataWidth-1:0] oldValue,
	output logic                 error
);

	logic [addrWidth-1:0] memAddr;
	logic                 writeEnable;
	logic [dataWidth-1:0] writeData;
	logic [dataWidth-1:0] readData;
	amoOp                 aluOp;
	laneSize              aluSize;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluResult;
	logic                 aluInvalid;

	amoSequencer #(.addrWidth(addrWidth)) sequencer
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.size(size),
		.addr(addr),
		.operand(operand),
		.ack(ack),
		.oldValue(oldValue),
		.error(error),
		.memAddr(memAddr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readData(readData),
		.aluOp(aluOp),
		.aluSize(aluSize),
		.aluB(aluB),
		.aluResult(aluResult),
		.aluInvalid(aluInvalid)
	);

	amoMemory #(.addrWidth(addrWidth)) memory
	(
		.clk(clk),
		.addr(memAddr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readData(readData)
	);

	// The memory word feeds the ALU directly
	amoAlu alu
	(
		.op(aluOp),
		.size(aluSize),
		.a(readData),
		.b(aluB),
		.result(aluResult),
		.invalid(aluInvalid)
	);

endmodule

// File: bench/amoVectors.svh
// Columns: op, lane size, address, operand, hold cycles after ack,
// expected old value, expected error, old value checked

typedef struct packed
{
	logic [3:0]           op;
	logic [1:0]           size;
	logic [3:0]           addr;
	logic [dataWidth-1:0] operand;
	logic [7:0]           hold;
	logic [dataWidth-1:0] expOld;
	logic                 expErr;
	logic                 checkOld;
} vectorEntry;

vectorEntry vectors [$];

task automatic addVector
(
	input logic [3:0]           vop,
	input logic [1:0]           vsize,
	input logic [3:0]           vaddr,
	input logic [dataWidth-1:0] voperand,
	input logic [7:0]           vhold,
	input logic [dataWidth-1:0] vexpOld,
	input logic                 vexpErr,
	input logic                 vcheckOld
);
	vectorEntry entry;
	entry = {vop, vsize, vaddr, voperand, vhold, vexpOld, vexpErr, vcheckOld};
	vectors.push_back(entry);
endtask

task automatic loadVectors;
	// First touch of each address, old contents are unknown
	addVector(opSwap, laneDouble, 4'd0, 64'hFFFFFFFFFFFFFFFF, 0, 64'h0, 1'b0, 1'b0);
	addVector(opSwap, laneDouble, 4'd1, 64'h0123456789ABCDEF, 0, 64'h0, 1'b0, 1'b0);
	addVector(opSwap, laneDouble, 4'd2, 64'h807F807F807F807F, 0, 64'h0, 1'b0, 1'b0);
	addVector(opSwap, laneDouble, 4'd3, 64'h0011223344556677, 0, 64'h0, 1'b0, 1'b0);
	addVector(opSwap, laneDouble, 4'd4, 64'h0000000000000010, 0, 64'h0, 1'b0, 1'b0);
	// Add with lane overflow, each result read back by the next swap
	addVector(opAdd,  laneByte,   4'd0, 64'h0101010101010101, 1, 64'hFFFFFFFFFFFFFFFF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd0, 64'h8000FFFF7FFF0001, 0, 64'h0000000000000000, 1'b0, 1'b1);
	addVector(opAdd,  laneHalf,   4'd0, 64'h800000010001FFFF, 0, 64'h8000FFFF7FFF0001, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd0, 64'hFFFFFFFF80000000, 0, 64'h0000000080000000, 1'b0, 1'b1);
	addVector(opAdd,  laneWord,   4'd0, 64'h0000000180000000, 0, 64'hFFFFFFFF80000000, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd0, 64'hFFFFFFFFFFFFFFFF, 0, 64'h0000000000000000, 1'b0, 1'b1);
	addVector(opAdd,  laneDouble, 4'd0, 64'h0000000000000002, 0, 64'hFFFFFFFFFFFFFFFF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd0, 64'h0000000000000000, 0, 64'h0000000000000001, 1'b0, 1'b1);
	// Shifts, counts carry high bits that must be ignored
	addVector(opShl,  laneByte,   4'd1, 64'hF9F9F9F9F9F9F9F9, 0, 64'h0123456789ABCDEF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd1, 64'h0123456789ABCDEF, 0, 64'h02468ACE12569ADE, 1'b0, 1'b1);
	addVector(opShr,  laneHalf,   4'd1, 64'hFFF4FFF4FFF4FFF4, 0, 64'h0123456789ABCDEF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd1, 64'h0123456789ABCDEF, 0, 64'h00120456089A0CDE, 1'b0, 1'b1);
	addVector(opShl,  laneWord,   4'd1, 64'hFFFFFFE8FFFFFFE8, 0, 64'h0123456789ABCDEF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd1, 64'h0123456789ABCDEF, 0, 64'h23456700ABCDEF00, 1'b0, 1'b1);
	addVector(opShr,  laneDouble, 4'd1, 64'hFFFFFFFFFFFFFFD0, 0, 64'h0123456789ABCDEF, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd1, 64'h0000000000000000, 0, 64'h00000123456789AB, 1'b0, 1'b1);
	// Signed and unsigned compares on lanes with opposite sign bits
	addVector(opMin,  laneByte,   4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd2, 64'h807F807F807F807F, 0, 64'h8080808080808080, 1'b0, 1'b1);
	addVector(opMinu, laneByte,   4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd2, 64'h807F807F807F807F, 0, 64'h7F7F7F7F7F7F7F7F, 1'b0, 1'b1);
	addVector(opMax,  laneHalf,   4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd2, 64'h807F807F807F807F, 0, 64'h7F807F807F807F80, 1'b0, 1'b1);
	addVector(opMaxu, laneHalf,   4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	addVector(opMinu, laneWord,   4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd2, 64'h807F807F807F807F, 0, 64'h7F807F807F807F80, 1'b0, 1'b1);
	addVector(opMax,  laneDouble, 4'd2, 64'h7F807F807F807F80, 0, 64'h807F807F807F807F, 1'b0, 1'b1);
	// Bitwise ops
	addVector(opAnd,  laneDouble, 4'd2, 64'h0F0F0F0F0F0F0F0F, 0, 64'h7F807F807F807F80, 1'b0, 1'b1);
	addVector(opOr,   laneByte,   4'd2, 64'h00F000F000F000F0, 0, 64'h0F000F000F000F00, 1'b0, 1'b1);
	addVector(opXor,  laneHalf,   4'd2, 64'hFFFF0000FFFF0000, 0, 64'h0FF00FF00FF00FF0, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd2, 64'h0000000000000000, 0, 64'hF00F0FF0F00F0FF0, 1'b0, 1'b1);
	// Unknown op codes leave the word alone
	addVector(4'd12,  laneDouble, 4'd3, 64'hFFFFFFFFFFFFFFFF, 2, 64'h0011223344556677, 1'b1, 1'b1);
	addVector(4'd15,  laneByte,   4'd3, 64'h0000000000000000, 0, 64'h0011223344556677, 1'b1, 1'b1);
	addVector(opSwap, laneDouble, 4'd3, 64'h0000000000000000, 0, 64'h0011223344556677, 1'b0, 1'b1);
	// Requests held past ack must update once
	addVector(opAdd,  laneDouble, 4'd4, 64'h0000000000000001, 5, 64'h0000000000000010, 1'b0, 1'b1);
	addVector(opAdd,  laneWord,   4'd4, 64'h0000000100000001, 3, 64'h0000000000000011, 1'b0, 1'b1);
	addVector(opSwap, laneDouble, 4'd4, 64'h0000000000000000, 0, 64'h0000000100000012, 1'b0, 1'b1);
endtask

// File: bench/amoUnitTb.sv
module amoUnitTb import amoPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Edges to wait for ack before a request counts as hung
	localparam int ackTimeout = 20;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 req;
	amoOp                 op;
	laneSize              size;
	logic [3:0]           addr;
	logic [dataWidth-1:0] operand;
	logic                 ack;
	logic [dataWidth-1:0] oldValue;
	logic                 error;

	int passCount;
	int failCount;
	bit testFailed;
	bit hung;

	`include "amoVectors.svh"

	amoUnit #(.addrWidth(4)) uut
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.size(size),
		.addr(addr),
		.operand(operand),
		.ack(ack),
		.oldValue(oldValue),
		.error(error)
	);

	always #2 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	task automatic compareValue
	(
		input logic [dataWidth-1:0] actual,
		input logic [dataWidth-1:0] expected,
		input string                what
	);
		if (actual !== expected)
		begin
			$display("Mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			testFailed = 1'b1;
		end
	endtask

	// Polls ack on falling edges until it reaches the level or time runs out
	task automatic waitForAck(input logic level, output bit timedOut);
		int cycles;
		cycles = 0;
		while (ack !== level && cycles < ackTimeout)
		begin
			@(negedge clk);
			cycles++;
		end
		timedOut = (ack !== level);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		vectorEntry v;
		bit timedOut;
		reset = 1'b1;
		req = 1'b0;
		op = opSwap;
		size = laneByte;
		addr = '0;
		operand = '0;
		passCount = 0;
		failCount = 0;
		hung = 1'b0;
		loadVectors();

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		testFailed = 1'b0;
		compareValue(64'(ack), 64'd0, "ack after reset");
		$display("Test reset: %s", testFailed ? "FAILED" : "ok");
		if (testFailed)
			failCount++;
		else
			passCount++;

		for (int i = 0; i < vectors.size() && !hung; i++)
		begin
			v = vectors[i];
			testFailed = 1'b0;
			op = amoOp'(v.op);
			size = laneSize'(v.size);
			addr = v.addr;
			operand = v.operand;
			req = 1'b1;
			waitForAck(1'b1, timedOut);
			if (timedOut)
			begin
				$display("Test %0d hung, ack never rose", i);
				hung = 1'b1;
				testFailed = 1'b1;
			end
			else
			begin
				if (v.checkOld)
					compareValue(oldValue, v.expOld, "oldValue");
				compareValue(64'(error), 64'(v.expErr), "error");
				// Response must stay put while req is held
				for (int h = 0; h < v.hold; h++)
				begin
					@(negedge clk);
					compareValue(64'(ack), 64'd1, "ack while req held");
					if (v.checkOld)
						compareValue(oldValue, v.expOld, "oldValue while req held");
					compareValue(64'(error), 64'(v.expErr), "error while req held");
				end
				req = 1'b0;
				waitForAck(1'b0, timedOut);
				if (timedOut)
				begin
					$display("Test %0d hung, ack never fell after req dropped", i);
					hung = 1'b1;
					testFailed = 1'b1;
				end
			end
			$display("Test %0d op %0d size %0d addr %0d: %s", i, v.op, v.size, v.addr,
				testFailed ? "FAILED" : "ok");
			if (testFailed)
				failCount++;
			else
				passCount++;
		end

		$display("Passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && !hung)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+bench
rtl/amoPkg.sv
rtl/amoAlu.sv
rtl/amoMemory.sv
rtl/amoSequencer.sv
rtl/amoUnit.sv
bench/amoUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the AMO unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=amoUnitSim
logFile=sim.log

verilator --binary --assert --Wno-fatal \
	--top-module amoUnitTb \
	-f verilog.f \
	--Mdir "$buildDir" \
	-o "$simName"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
